// ==== design/fifo_pkg.sv ====
package fifo_pkg;

   // states of the flag FSM, one instance per clock domain
   typedef enum logic [1:0] {
      st_init,
      st_empty,
      st_default,
      st_full
   } fifo_state_e;

   // default sizes give 32-bit writes and byte reads over 64 bytes
   localparam int DEF_W_DATA_W = 32;
   localparam int DEF_R_DATA_W = 8;
   localparam int DEF_ADDR_W = 6;

   // widest pointer the gray helpers handle
   localparam int GRAY_W = 32;

   function automatic logic [GRAY_W-1:0] bin2gray(input logic [GRAY_W-1:0] bin);
      return bin ^ (bin >> 1);
   endfunction

   // each binary bit is the xor of all gray bits above and at its position
   function automatic logic [GRAY_W-1:0] gray2bin(input logic [GRAY_W-1:0] gray);
      logic [GRAY_W-1:0] bin;
      bin[GRAY_W-1] = gray[GRAY_W-1];
      for (int i = GRAY_W - 2; i >= 0; i--) begin
         bin[i] = bin[i+1] ^ gray[i];
      end
      return bin;
   endfunction

endpackage

// ==== design/gray_counter.sv ====
module gray_counter #(
   parameter int W = fifo_pkg::DEF_ADDR_W
) (
   input  logic         clk,
   input  logic         rst_n,
   input  logic         en,
   output logic [W-1:0] gray
);

   localparam int GW = fifo_pkg::GRAY_W;

   // binary count stays local, only its gray image leaves the module
   logic [W-1:0] bin_q;
   logic [W-1:0] bin_next;

   assign bin_next = bin_q + W'(1);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         bin_q <= '0;
         gray  <= '0;
      end else if (en) begin
         bin_q <= bin_next;
         // registered output so the other domain sees one bit toggle per step
         gray  <= W'(fifo_pkg::bin2gray(GW'(bin_next)));
      end
   end

endmodule

// ==== design/ram_t2p_asym.sv ====
module ram_t2p_asym #(
   parameter int W_DATA_W = fifo_pkg::DEF_W_DATA_W,
   parameter int R_DATA_W = fifo_pkg::DEF_R_DATA_W,
   parameter int ADDR_W   = fifo_pkg::DEF_ADDR_W,
   // storage is organised in narrow words
   localparam int MIN_W    = (W_DATA_W < R_DATA_W) ? W_DATA_W : R_DATA_W,
   localparam int W_SHIFT  = $clog2(W_DATA_W / MIN_W),
   localparam int R_SHIFT  = $clog2(R_DATA_W / MIN_W),
   localparam int W_ADDR_W = ADDR_W - W_SHIFT,
   localparam int R_ADDR_W = ADDR_W - R_SHIFT
) (
   // write port
   input  logic                w_clk,
   input  logic                w_en,
   input  logic [W_ADDR_W-1:0] w_addr,
   input  logic [W_DATA_W-1:0] w_data,

   // read port
   input  logic                r_clk,
   input  logic                r_en,
   input  logic [R_ADDR_W-1:0] r_addr,
   output logic [R_DATA_W-1:0] r_data
);

   // narrow words per access on each side
   localparam int W_WORDS = 1 << W_SHIFT;
   localparam int R_WORDS = 1 << R_SHIFT;
   localparam int DEPTH   = 1 << ADDR_W;

   logic [MIN_W-1:0] mem [DEPTH];

   // narrow address of the first word touched by an access
   logic [ADDR_W-1:0] w_base;
   logic [ADDR_W-1:0] r_base;

   assign w_base = ADDR_W'(w_addr) << W_SHIFT;
   assign r_base = ADDR_W'(r_addr) << R_SHIFT;

   // wide write scatters into consecutive narrow slots, lowest slice first
   always_ff @(posedge w_clk) begin
      if (w_en) begin
         for (int k = 0; k < W_WORDS; k++) begin
            mem[w_base | ADDR_W'(k)] <= w_data[k*MIN_W +: MIN_W];
         end
      end
   end

   // registered read gathers narrow slots in the same little-endian order
   always_ff @(posedge r_clk) begin
      if (r_en) begin
         for (int k = 0; k < R_WORDS; k++) begin
            r_data[k*MIN_W +: MIN_W] <= mem[r_base | ADDR_W'(k)];
         end
      end
   end

endmodule

// ==== design/fifo_async.sv ====
module fifo_async #(
   parameter int W_DATA_W = fifo_pkg::DEF_W_DATA_W,
   parameter int R_DATA_W = fifo_pkg::DEF_R_DATA_W,
   parameter int ADDR_W   = fifo_pkg::DEF_ADDR_W
) (
   input  logic                rst_n,

   // write domain
   input  logic                w_clk,
   input  logic                w_en,
   input  logic [W_DATA_W-1:0] w_data,
   output logic                w_empty,
   output logic                w_full,
   output logic [ADDR_W:0]     w_level,

   // read domain
   input  logic                r_clk,
   input  logic                r_en,
   output logic [R_DATA_W-1:0] r_data,
   output logic                r_empty,
   output logic                r_full,
   output logic [ADDR_W:0]     r_level
);

   // the wide side addresses whole groups of narrow words
   localparam int MIN_W    = (W_DATA_W < R_DATA_W) ? W_DATA_W : R_DATA_W;
   localparam int W_SHIFT  = $clog2(W_DATA_W / MIN_W);
   localparam int R_SHIFT  = $clog2(R_DATA_W / MIN_W);
   localparam int W_ADDR_W = ADDR_W - W_SHIFT;
   localparam int R_ADDR_W = ADDR_W - R_SHIFT;
   localparam int GW       = fifo_pkg::GRAY_W;

   // sizes and steps in narrow words
   localparam logic [ADDR_W:0] FIFO_SIZE = {1'b1, {ADDR_W{1'b0}}};
   localparam logic [ADDR_W:0] W_INCR    = {{ADDR_W{1'b0}}, 1'b1} << W_SHIFT;
   localparam logic [ADDR_W:0] R_INCR    = {{ADDR_W{1'b0}}, 1'b1} << R_SHIFT;

   // accepted strobes
   logic w_acc;
   logic r_acc;

   // gray pointers at their source
   logic [W_ADDR_W-1:0] w_wgray;
   logic [R_ADDR_W-1:0] r_rgray;

   // two-flop copies in the opposite domain
   logic [W_ADDR_W-1:0] r_wgray_s0;
   logic [W_ADDR_W-1:0] r_wgray_s1;
   logic [R_ADDR_W-1:0] w_rgray_s0;
   logic [R_ADDR_W-1:0] w_rgray_s1;

   // binary pointers, prefix names the domain they live in
   logic [W_ADDR_W-1:0] w_wbin;
   logic [W_ADDR_W-1:0] r_wbin;
   logic [R_ADDR_W-1:0] r_rbin;
   logic [R_ADDR_W-1:0] w_rbin;

   // pointers normalised to narrow words
   logic [ADDR_W-1:0] w_wptr_n;
   logic [ADDR_W-1:0] w_rptr_n;
   logic [ADDR_W-1:0] r_wptr_n;
   logic [ADDR_W-1:0] r_rptr_n;

   // raw levels, zero also means a whole depth
   logic [ADDR_W-1:0] w_level_int;
   logic [ADDR_W-1:0] r_level_int;

   fifo_pkg::fifo_state_e w_st;
   fifo_pkg::fifo_state_e w_st_nxt;
   fifo_pkg::fifo_state_e r_st;
   fifo_pkg::fifo_state_e r_st_nxt;

   assign w_acc = w_en & ~w_full;
   assign r_acc = r_en & ~r_empty;

   // write pointer into the read domain
   always_ff @(posedge r_clk or negedge rst_n) begin
      if (!rst_n) begin
         r_wgray_s0 <= '0;
         r_wgray_s1 <= '0;
      end else begin
         r_wgray_s0 <= w_wgray;
         r_wgray_s1 <= r_wgray_s0;
      end
   end

   // read pointer into the write domain
   always_ff @(posedge w_clk or negedge rst_n) begin
      if (!rst_n) begin
         w_rgray_s0 <= '0;
         w_rgray_s1 <= '0;
      end else begin
         w_rgray_s0 <= r_rgray;
         w_rgray_s1 <= w_rgray_s0;
      end
   end

   assign w_wbin = W_ADDR_W'(fifo_pkg::gray2bin(GW'(w_wgray)));
   assign r_wbin = W_ADDR_W'(fifo_pkg::gray2bin(GW'(r_wgray_s1)));
   assign r_rbin = R_ADDR_W'(fifo_pkg::gray2bin(GW'(r_rgray)));
   assign w_rbin = R_ADDR_W'(fifo_pkg::gray2bin(GW'(w_rgray_s1)));

   assign w_wptr_n = ADDR_W'(w_wbin) << W_SHIFT;
   assign w_rptr_n = ADDR_W'(w_rbin) << R_SHIFT;
   assign r_wptr_n = ADDR_W'(r_wbin) << W_SHIFT;
   assign r_rptr_n = ADDR_W'(r_rbin) << R_SHIFT;

   assign w_level_int = w_wptr_n - w_rptr_n;
   assign r_level_int = r_wptr_n - r_rptr_n;

   always_ff @(posedge w_clk or negedge rst_n) begin
      if (!rst_n) begin
         w_st <= fifo_pkg::st_init;
      end else begin
         w_st <= w_st_nxt;
      end
   end

   always_ff @(posedge r_clk or negedge rst_n) begin
      if (!rst_n) begin
         r_st <= fifo_pkg::st_init;
      end else begin
         r_st <= r_st_nxt;
      end
   end

   // blocking flags come straight from the state
   assign w_full  = (w_st == fifo_pkg::st_init) || (w_st == fifo_pkg::st_full);
   assign r_empty = (r_st == fifo_pkg::st_init) || (r_st == fifo_pkg::st_empty);

   // write side FSM
   always_comb begin
      w_st_nxt = w_st;
      w_empty  = 1'b0;
      w_level  = {1'b0, w_level_int};
      case (w_st)
         fifo_pkg::st_init: begin
            w_empty  = 1'b1;
            w_st_nxt = fifo_pkg::st_default;
         end
         fifo_pkg::st_full: begin
            // pointers a whole depth apart wrap the difference to zero
            if (w_level_int == '0) begin
               w_level = FIFO_SIZE;
            end else if ({1'b0, w_level_int} <= FIFO_SIZE - W_INCR) begin
               w_st_nxt = fifo_pkg::st_default;
            end
         end
         default: begin
            w_empty = (w_level_int == '0);
            // full once the accepted write leaves less than one wide slot
            if (w_acc && ({1'b0, w_level_int} + W_INCR > FIFO_SIZE - W_INCR)) begin
               w_st_nxt = fifo_pkg::st_full;
            end
         end
      endcase
   end

   // read side FSM
   always_comb begin
      r_st_nxt = r_st;
      r_full   = 1'b0;
      r_level  = {1'b0, r_level_int};
      case (r_st)
         fifo_pkg::st_init: begin
            r_full   = 1'b1;
            r_st_nxt = fifo_pkg::st_empty;
         end
         fifo_pkg::st_empty: begin
            if ({1'b0, r_level_int} >= R_INCR) begin
               r_st_nxt = fifo_pkg::st_default;
            end
         end
         default: begin
            if (r_level_int == '0) begin
               r_full  = 1'b1;
               r_level = FIFO_SIZE;
            end
            // empty once the accepted read leaves less than one read word
            if (r_acc && (r_level - R_INCR < R_INCR)) begin
               r_st_nxt = fifo_pkg::st_empty;
            end
         end
      endcase
   end

   gray_counter #(
      .W(W_ADDR_W)
   ) w_ptr_counter (
      .clk  (w_clk),
      .rst_n(rst_n),
      .en   (w_acc),
      .gray (w_wgray)
   );

   gray_counter #(
      .W(R_ADDR_W)
   ) r_ptr_counter (
      .clk  (r_clk),
      .rst_n(rst_n),
      .en   (r_acc),
      .gray (r_rgray)
   );

   ram_t2p_asym #(
      .W_DATA_W(W_DATA_W),
      .R_DATA_W(R_DATA_W),
      .ADDR_W  (ADDR_W)
   ) fifo_mem (
      .w_clk (w_clk),
      .w_en  (w_acc),
      .w_addr(w_wbin),
      .w_data(w_data),
      .r_clk (r_clk),
      .r_en  (r_acc),
      .r_addr(r_rbin),
      .r_data(r_data)
   );

endmodule

// ==== bench/fifo_async_checker.sv ====
module fifo_async_checker #(
   parameter int ADDR_W   = fifo_pkg::DEF_ADDR_W,
   parameter int R_DATA_W = fifo_pkg::DEF_R_DATA_W
) (
   input logic                  w_clk,
   input logic                  r_clk,
   input logic                  rst_n,
   input logic                  w_full,
   input logic                  w_empty,
   input logic [ADDR_W:0]       w_level,
   input logic [ADDR_W:0]       r_level,
   input logic                  r_acc,
   input logic [R_DATA_W-1:0]   r_data,
   input fifo_pkg::fifo_state_e w_st
);

   timeunit 1ns;
   timeprecision 1ps;

   localparam logic [ADDR_W:0] FIFO_SIZE = {1'b1, {ADDR_W{1'b0}}};

   // both flags are only allowed together in the init cycle
   flags_exclusive: assert property (@(posedge w_clk) disable iff (!rst_n)
      (w_st != fifo_pkg::st_init) |-> !(w_full && w_empty))
      else $error("w_full and w_empty high together");

   w_level_bound: assert property (@(posedge w_clk) disable iff (!rst_n)
      w_level <= FIFO_SIZE)
      else $error("w_level above FIFO size");

   r_level_bound: assert property (@(posedge r_clk) disable iff (!rst_n)
      r_level <= FIFO_SIZE)
      else $error("r_level above FIFO size");

   r_data_hold: assert property (@(posedge r_clk) disable iff (!rst_n)
      (!r_acc && !$isunknown(r_data)) |=> $stable(r_data))
      else $error("r_data changed without an accepted read");

endmodule

bind fifo_async fifo_async_checker #(
   .ADDR_W  (ADDR_W),
   .R_DATA_W(R_DATA_W)
) flag_checker (
   .w_clk  (w_clk),
   .r_clk  (r_clk),
   .rst_n  (rst_n),
   .w_full (w_full),
   .w_empty(w_empty),
   .w_level(w_level),
   .r_level(r_level),
   .r_acc  (r_acc),
   .r_data (r_data),
   .w_st   (w_st)
);

// ==== bench/fifo_async_tb.sv ====
module fifo_async_tb;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int W_DW        = fifo_pkg::DEF_W_DATA_W;
   localparam int R_DW        = fifo_pkg::DEF_R_DATA_W;
   localparam int ADDR_W      = fifo_pkg::DEF_ADDR_W;
   localparam int RATIO       = W_DW / R_DW;
   localparam int PERIOD_NS   = 4;
   localparam int RAND_CYCLES = 300;
   localparam string CASE_FILE = "bench/fifo_async_cases.txt";

   logic              rst_n;
   logic              w_clk;
   logic              w_en;
   logic [W_DW-1:0]   w_data;
   logic              w_empty;
   logic              w_full;
   logic [ADDR_W:0]   w_level;
   logic              r_clk;
   logic              r_en;
   logic [R_DW-1:0]   r_data;
   logic              r_empty;
   logic              r_full;
   logic [ADDR_W:0]   r_level;

   // parsed case file
   string             cmd_q[$];
   string             arg_q[$];
   int                case_cycles;
   int                limit_ns;

   // expected bytes in the order they leave the FIFO
   logic [R_DW-1:0]   sb[$];
   int                checks;
   int                errors;
   int                tests_run;
   int                tests_failed;
   int                test_err_start;
   string             test_name;
   logic [31:0]       w_seed;
   logic [31:0]       r_seed;
   logic [7:0]        byte_seq;

   fifo_async #(
      .W_DATA_W(W_DW),
      .R_DATA_W(R_DW),
      .ADDR_W  (ADDR_W)
   ) fifo_async_inst (
      .rst_n  (rst_n),
      .w_clk  (w_clk),
      .w_en   (w_en),
      .w_data (w_data),
      .w_empty(w_empty),
      .w_full (w_full),
      .w_level(w_level),
      .r_clk  (r_clk),
      .r_en   (r_en),
      .r_data (r_data),
      .r_empty(r_empty),
      .r_full (r_full),
      .r_level(r_level)
   );

   initial begin
      w_clk = 1'b0;
      r_clk = 1'b0;
   end

   always #(PERIOD_NS / 2) w_clk = ~w_clk;

   // read clock runs 1 ns behind the write clock
   always begin
      #1;
      forever #(PERIOD_NS / 2) r_clk = ~r_clk;
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("Mismatch %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic note_failure(input string msg);
      errors++;
      $display("error: %s", msg);
   endtask

   // pushes the narrow words of an accepted write, lowest slice first
   task automatic push_word(input logic [W_DW-1:0] data);
      for (int k = 0; k < RATIO; k++) begin
         sb.push_back(data[k*R_DW +: R_DW]);
      end
   endtask

   // w_full seen at drive time is the value the next edge uses
   task automatic write_word(input logic [W_DW-1:0] data);
      @(posedge w_clk);
      #1;
      w_en = 1'b1;
      w_data = data;
      if (!w_full) begin
         push_word(data);
      end
      @(posedge w_clk);
      #1;
      w_en = 1'b0;
   endtask

   task automatic read_byte(input bit has_exp, input logic [R_DW-1:0] exp);
      logic [R_DW-1:0] sb_byte;
      do begin
         @(posedge r_clk);
         #1;
      end while (r_empty);
      r_en = 1'b1;
      @(posedge r_clk);
      #1;
      r_en = 1'b0;
      if (sb.size() == 0) begin
         note_failure("read accepted while no written data was outstanding");
      end else begin
         sb_byte = sb.pop_front();
         check_value("r_data", sb_byte, r_data);
      end
      if (has_exp) begin
         check_value("r_data (case file)", exp, r_data);
      end
   endtask

   task automatic rejected_read();
      logic [R_DW-1:0] held;
      @(posedge r_clk);
      #1;
      held = r_data;
      check_value("r_empty", 1, r_empty);
      r_en = 1'b1;
      @(posedge r_clk);
      #1;
      r_en = 1'b0;
      check_value("r_data", held, r_data);
   endtask

   task automatic check_levels(input int lvl);
      @(posedge r_clk);
      #1;
      check_value("r_level", lvl, r_level);
      check_value("r_empty", lvl == 0, r_empty);
      check_value("r_full", lvl == (1 << ADDR_W), r_full);
      @(posedge w_clk);
      #1;
      check_value("w_level", lvl, w_level);
      check_value("w_empty", lvl == 0, w_empty);
      check_value("w_full", lvl == (1 << ADDR_W), w_full);
      check_value("scoreboard level", lvl, sb.size());
   endtask

   task automatic check_reset_state();
      @(posedge r_clk);
      #1;
      check_value("r_empty", 1, r_empty);
      check_value("r_full", 0, r_full);
      check_value("r_level", 0, r_level);
      @(posedge w_clk);
      #1;
      check_value("w_empty", 1, w_empty);
      check_value("w_full", 0, w_full);
      check_value("w_level", 0, w_level);
   endtask

   task automatic load_cases();
      int fd;
      string line;
      string cmd;
      string arg;
      fd = $fopen(CASE_FILE, "r");
      if (fd == 0) begin
         note_failure("could not open the case file");
         return;
      end
      while ($fgets(line, fd)) begin
         if (line.len() > 1 && line[0] != "#" && $sscanf(line, "%s %s", cmd, arg) == 2) begin
            cmd_q.push_back(cmd);
            arg_q.push_back(arg);
            case (cmd)
               "W", "R", "X", "L", "S": case_cycles += 4;
               "G", "D": case_cycles += 4 * arg.atoi();
               "I": case_cycles += arg.atoi();
               "Q": case_cycles += 10;
               default: case_cycles += 2;
            endcase
         end
      end
      $fclose(fd);
   endtask

   task automatic start_test(input string name);
      test_name = name;
      test_err_start = errors;
      byte_seq = 8'h00;
   endtask

   task automatic end_test();
      tests_run++;
      if (errors == test_err_start) begin
         $display("test %s passed", test_name);
      end else begin
         tests_failed++;
         $display("test %s failed with %0d errors", test_name, errors - test_err_start);
      end
   endtask

   task automatic run_cases();
      logic [W_DW-1:0] word;
      for (int i = 0; i < cmd_q.size(); i++) begin
         case (cmd_q[i])
            "T": start_test(arg_q[i]);
            "S": check_reset_state();
            "W": write_word(arg_q[i].atohex());
            "G": begin
               // words whose bytes count up from zero
               repeat (arg_q[i].atoi()) begin
                  for (int k = 0; k < RATIO; k++) begin
                     word[k*R_DW +: R_DW] = byte_seq;
                     byte_seq++;
                  end
                  write_word(word);
               end
            end
            "R": read_byte(1'b1, arg_q[i].atohex());
            "D": repeat (arg_q[i].atoi()) read_byte(1'b0, '0);
            "X": rejected_read();
            "Q": begin
               if (arg_q[i] == "e") begin
                  do begin
                     @(posedge r_clk);
                     #1;
                  end while (r_empty);
               end else begin
                  do begin
                     @(posedge w_clk);
                     #1;
                  end while (w_full);
               end
            end
            "I": repeat (arg_q[i].atoi()) @(posedge w_clk);
            "L": check_levels(arg_q[i].atoi());
            "E": end_test();
            default: note_failure({"unknown command in case file: ", cmd_q[i]});
         endcase
      end
   endtask

   task automatic random_phase();
      start_test("random");
      fork
         begin
            repeat (RAND_CYCLES) begin
               @(posedge w_clk);
               #1;
               w_seed = lcg_next(w_seed);
               w_en = w_seed[16];
               w_seed = lcg_next(w_seed);
               w_data = w_seed;
               if (w_en && !w_full) begin
                  push_word(w_data);
               end
            end
            @(posedge w_clk);
            #1;
            w_en = 1'b0;
         end
         begin
            bit pend;
            logic [R_DW-1:0] exp;
            pend = 1'b0;
            repeat (RAND_CYCLES) begin
               @(posedge r_clk);
               #1;
               if (pend) begin
                  check_value("r_data", exp, r_data);
               end
               r_seed = lcg_next(r_seed);
               r_en = r_seed[17];
               pend = r_en && !r_empty;
               if (pend) begin
                  exp = sb.pop_front();
               end
            end
            @(posedge r_clk);
            #1;
            r_en = 1'b0;
            if (pend) begin
               check_value("r_data", exp, r_data);
            end
         end
      join
      // whatever is left must still come out in order
      while (sb.size() > 0) begin
         read_byte(1'b0, '0);
      end
      repeat (8) @(posedge w_clk);
      check_levels(0);
      end_test();
   endtask

   initial begin
      rst_n = 1'b0;
      w_en = 1'b0;
      w_data = '0;
      r_en = 1'b0;
      limit_ns = 0;
      case_cycles = 0;
      checks = 0;
      errors = 0;
      tests_run = 0;
      tests_failed = 0;
      w_seed = 32'h2ec3_36b8;
      r_seed = lcg_next(32'h2ec3_36b8);
      load_cases();
      limit_ns = (4 * case_cycles + RAND_CYCLES + 4 * (1 << ADDR_W)) * PERIOD_NS;
      repeat (3) @(posedge w_clk);
      // the read clock trails by 1 ns, so release after its third edge
      @(posedge r_clk);
      #1;
      rst_n = 1'b1;
      run_cases();
      random_phase();
      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

   initial begin
      wait (limit_ns != 0);
      #(limit_ns * 1ns);
      $display("error: timeout, the tests did not complete in %0d ns", limit_ns);
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

// ==== bench/fifo_async_cases.txt ====
# cmd arg: T name, S reset check, W hex word, G n counting words, R expected hex byte
# D n bytes, X rejected read, Q e|f wait flag low, I n idle, L decimal level, E end
T reset
S 0
E 0
T width
W 44332211
W 88776655
Q e
R 11
R 22
R 33
R 44
R 55
R 66
R 77
R 88
I 8
L 0
E 0
T fill
G 17
I 8
L 64
D 64
X 0
I 8
L 0
E 0
T level
W a1b2c3d4
W 01020304
W 55aa55aa
I 8
L 12
R d4
R c3
D 5
I 8
L 5
E 0

// ==== verilog.f ====
design/fifo_pkg.sv
design/gray_counter.sv
design/ram_t2p_asym.sv
design/fifo_async.sv
bench/fifo_async_checker.sv
bench/fifo_async_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the FIFO testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
   --top-module fifo_async_tb \
   -f verilog.f \
   -o sim_fifo_async
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/sim_fifo_async > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Simulation finished: PASS" "$LOG"; then
   exit 0
else
   echo "pass message not found in $LOG"
   exit 1
fi
